/* files.f */
+incdir+logic
logic/axi_monitor_pkg.sv
logic/channel_stability_checker.sv
logic/burst_length_tracker.sv
logic/axi_write_checker.sv
logic/axi_read_checker.sv
logic/violation_reporter.sv
logic/axi_protocol_monitor.sv
verification/tb_axi_protocol_monitor.sv

/* run_sim.sh */
#!/bin/sh
# Builds the AXI4 monitor testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_axi_protocol_monitor -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0

/* verification/tb_axi_protocol_monitor.sv */
// Self-checking testbench that drives random AXI4 traffic and faults into the monitor each cycle
`default_nettype none

`include "axi_monitor_consts.svh"

module tb_axi_protocol_monitor;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_CYCLES = 6000;
	// Fault free cycles at the start
	localparam int LEGAL_CYCLES = 1000;
	localparam int FAULT_GAP = 30;
	localparam int TIMEOUT_NS = (NUM_CYCLES + 8 + 10) * 4 + 400;

	logic aclk = 1'b0;
	logic rst;
	logic [`AXI_MON_ADDR_WIDTH-1:0] awaddr, araddr;
	logic [`AXI_MON_LEN_WIDTH-1:0] awlen, arlen;
	logic [2:0] awsize, arsize;
	logic [1:0] awburst, arburst, bresp, rresp;
	logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rlast, rvalid, rready;
	logic [`AXI_MON_DATA_WIDTH-1:0] wdata, rdata;
	logic [`AXI_MON_STRB_WIDTH-1:0] wstrb;
	logic violation_valid;
	logic [`AXI_MON_VIOL_WIDTH-1:0] violation_word, violation_sticky;
	logic [15:0] violation_count;

	// LFSR state stepped once per random bit
	logic [31:0] lfsr = 32'd77;

	// Model history of each channel's stall and payload copy, in the order AW W B AR R
	bit st_stall [5];
	logic [72:0] st_copy [5];
	// Queued burst lengths and head beat count with index 0 for write and 1 for read
	int lens [2][$];
	int beat [2];
	int done_cnt;
	logic [`AXI_MON_VIOL_WIDTH-1:0] pred_q, exp_sticky;
	int exp_count;
	bit aw_hs_q, w_hs_q, b_hs_q, ar_hs_q, r_hs_q;

	// Driver bookkeeping
	int wr_out, rd_out, b_owed;
	int wq [$];
	int rq [$];
	bit w_active, r_active, extra_w, extra_r, extra_b;
	int w_len, w_beat, r_len, r_beat;
	// Pending fault kind, or -1 when none is waiting for its chance
	int fault;
	int errors, checks;

	axi_protocol_monitor i_dut (
		.aclk(aclk), .rst(rst),
		.awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
		.awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.violation_valid(violation_valid), .violation_word(violation_word),
		.violation_sticky(violation_sticky), .violation_count(violation_count)
	);

	always #2 aclk = ~aclk;

	function automatic logic [31:0] rnd(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
		end
	endtask

	// A stalled transfer must come back unchanged and still valid
	task automatic stab_step(input int c, input bit v, input bit r, input logic [72:0] p,
			output bit u, output bit d);
		u = st_stall[c] && v && (p != st_copy[c]);
		d = st_stall[c] && !v;
		st_stall[c] = v && !r;
		if (v && !r) begin
			st_copy[c] = p;
		end
	endtask

	// Beat number length+1 of the oldest burst carries last and bursts past four are ignored
	task automatic burst_step(input int dir, input bit addr_hs, input int len, input bit beat_hs,
			input bit last, output bit early, output bit missing, output bit noreq, output bit done);
		bit fin;
		early = 0;
		missing = 0;
		noreq = 0;
		done = 0;
		if (beat_hs) begin
			if (lens[dir].size() == 0) begin
				noreq = 1;
			end else begin
				fin = (beat[dir] == lens[dir][0]);
				missing = fin && !last;
				early = !fin && last;
				if (fin || last) begin
					void'(lens[dir].pop_front());
					beat[dir] = 0;
					done = 1;
				end else begin
					beat[dir]++;
				end
			end
		end
		if (addr_hs && lens[dir].size() < `AXI_MON_MAX_OUTSTANDING) begin
			lens[dir].push_back(len);
		end
	endtask

	// The reference model predicts the word registered at each rising edge
	always @(posedge aclk) begin
		axi_monitor_pkg::violation_word_u v;
		bit u, d, e, m, n, dn, take;
		v.raw = '0;
		if (rst) begin
			for (int c = 0; c < 5; c++) begin
				st_stall[c] = 0;
			end
			lens[0].delete();
			lens[1].delete();
			beat[0] = 0;
			beat[1] = 0;
			done_cnt = 0;
		end else begin
			stab_step(0, awvalid, awready, 73'({awaddr, awlen, awsize, awburst}), u, d);
			v.named.wr.aw_unstable = u;
			v.named.wr.aw_valid_dropped = d;
			stab_step(1, wvalid, wready, {wdata, wstrb, wlast}, u, d);
			v.named.wr.w_unstable = u;
			v.named.wr.w_valid_dropped = d;
			stab_step(2, bvalid, bready, 73'(bresp), u, d);
			v.named.wr.b_unstable = u;
			v.named.wr.b_valid_dropped = d;
			stab_step(3, arvalid, arready, 73'({araddr, arlen, arsize, arburst}), u, d);
			v.named.rd.ar_unstable = u;
			v.named.rd.ar_valid_dropped = d;
			stab_step(4, rvalid, rready, 73'({rdata, rresp, rlast}), u, d);
			v.named.rd.r_unstable = u;
			v.named.rd.r_valid_dropped = d;
			burst_step(0, awvalid && awready, int'(awlen), wvalid && wready, wlast, e, m, n, dn);
			v.named.wr.w_last_early = e;
			v.named.wr.w_last_missing = m;
			v.named.wr.w_without_request = n;
			// A response needs a finished write burst that has not been answered yet
			v.named.wr.b_without_request = bvalid && bready && (done_cnt == 0);
			take = bvalid && bready && (done_cnt > 0);
			if (dn && (done_cnt < `AXI_MON_MAX_OUTSTANDING || take)) begin
				done_cnt++;
			end
			if (take) begin
				done_cnt--;
			end
			burst_step(1, arvalid && arready, int'(arlen), rvalid && rready, rlast, e, m, n, dn);
			v.named.rd.r_last_early = e;
			v.named.rd.r_last_missing = m;
			v.named.rd.r_without_request = n;
		end
		pred_q = v.raw;
		exp_sticky = exp_sticky | v.raw;
		if (v.raw != 0) begin
			exp_count++;
		end
		aw_hs_q = !rst && awvalid && awready;
		w_hs_q = !rst && wvalid && wready;
		b_hs_q = !rst && bvalid && bready;
		ar_hs_q = !rst && arvalid && arready;
		r_hs_q = !rst && rvalid && rready;
	end

	// One falling edge worth of master and slave behaviour on both directions
	task automatic drive_cycle(input int cyc);
		logic [31:0] t;
		if (cyc >= LEGAL_CYCLES && cyc % FAULT_GAP == 0 && fault < 0) begin
			t = rnd(5);
			fault = int'(t) % 17;
		end
		// Account for the handshakes of the edge just passed
		if (aw_hs_q) wq.push_back(int'(awlen));
		if (ar_hs_q) rq.push_back(int'(arlen));
		if (w_hs_q) begin
			if (extra_w) begin
				extra_w = 0;
			end else if (wlast || w_beat == w_len) begin
				w_active = 0;
				b_owed++;
			end else begin
				w_beat++;
			end
		end
		if (b_hs_q) begin
			if (extra_b) begin
				extra_b = 0;
			end else begin
				b_owed--;
				wr_out--;
			end
		end
		if (r_hs_q) begin
			if (extra_r) begin
				extra_r = 0;
			end else if (rlast || r_beat == r_len) begin
				r_active = 0;
				rd_out--;
			end else begin
				r_beat++;
			end
		end
		t = rnd(8);
		awready = t[1:0] != 0;
		wready = t[3:2] != 0;
		bready = t[5:4] != 0;
		arready = t[6];
		rready = t[7];

		// New write bursts are held back while an unrequested beat is pending
		if (awvalid && !aw_hs_q) begin
			if (fault == 0) begin
				awaddr = awaddr ^ 32'd1;
				fault = -1;
			end else if (fault == 1) begin
				awvalid = 0;
				wr_out--;
				fault = -1;
			end
		end else begin
			awvalid = 0;
			if (wr_out < 4 && fault != 14 && fault != 16 && !extra_b && !extra_w &&
					rnd(1) != 0) begin
				awaddr = rnd(32);
				t = rnd(2);
				awlen = t[7:0];
				awvalid = 1;
				wr_out++;
			end
		end

		// The W master only sends data for bursts whose address went through
		if (wvalid && !w_hs_q) begin
			if (fault == 2) begin
				wdata = wdata ^ 64'd1;
				fault = -1;
			end else if (fault == 3) begin
				// A withdrawn unrequested beat is not offered again
				wvalid = 0;
				extra_w = 0;
				fault = -1;
			end
		end else begin
			wvalid = 0;
			if (!w_active && wq.size() > 0) begin
				w_len = wq.pop_front();
				w_active = 1;
				w_beat = 0;
			end
			if (w_active && rnd(1) != 0) begin
				wvalid = 1;
				wdata = {rnd(32), rnd(32)};
				t = rnd(8);
				wstrb = t[7:0];
				wlast = (w_beat == w_len);
				if (fault == 10 && w_len >= 1 && w_beat == w_len - 1) begin
					wlast = 1;
					fault = -1;
				end else if (fault == 11 && w_beat == w_len) begin
					wlast = 0;
					fault = -1;
				end
			end else if (fault == 16 && !w_active && wr_out == 0 && !awvalid) begin
				wvalid = 1;
				wlast = 1;
				extra_w = 1;
				fault = -1;
			end
		end

		// B slave
		if (bvalid && !b_hs_q) begin
			if (fault == 4) begin
				bresp = bresp ^ 2'd1;
				fault = -1;
			end else if (fault == 5) begin
				bvalid = 0;
				extra_b = 0;
				fault = -1;
			end
		end else begin
			bvalid = 0;
			if (b_owed > 0 && rnd(1) != 0) begin
				bvalid = 1;
				t = rnd(2);
				bresp = t[1:0];
			end else if (fault == 14 && wr_out == 0 && !awvalid && !wvalid) begin
				bvalid = 1;
				extra_b = 1;
				fault = -1;
			end
		end

		// AR master
		if (arvalid && !ar_hs_q) begin
			if (fault == 6) begin
				araddr = araddr ^ 32'd1;
				fault = -1;
			end else if (fault == 7) begin
				arvalid = 0;
				rd_out--;
				fault = -1;
			end
		end else begin
			arvalid = 0;
			if (rd_out < 4 && fault != 15 && !extra_r && rnd(1) != 0) begin
				araddr = rnd(32);
				t = rnd(2);
				arlen = t[7:0];
				arvalid = 1;
				rd_out++;
			end
		end

		// R beats follow accepted read addresses in order
		if (rvalid && !r_hs_q) begin
			if (fault == 8) begin
				rdata = rdata ^ 64'd1;
				fault = -1;
			end else if (fault == 9) begin
				rvalid = 0;
				extra_r = 0;
				fault = -1;
			end
		end else begin
			rvalid = 0;
			if (!r_active && rq.size() > 0) begin
				r_len = rq.pop_front();
				r_active = 1;
				r_beat = 0;
			end
			if (r_active && rnd(1) != 0) begin
				rvalid = 1;
				rdata = {rnd(32), rnd(32)};
				t = rnd(2);
				rresp = t[1:0];
				rlast = (r_beat == r_len);
				if (fault == 12 && r_len >= 1 && r_beat == r_len - 1) begin
					rlast = 1;
					fault = -1;
				end else if (fault == 13 && r_beat == r_len) begin
					rlast = 0;
					fault = -1;
				end
			end else if (fault == 15 && rd_out == 0 && !arvalid) begin
				rvalid = 1;
				rlast = 1;
				extra_r = 1;
				fault = -1;
			end
		end
	endtask

	initial begin
		rst = 1;
		{awaddr, awlen, awvalid, awready, wdata, wlast, wvalid, wready} = '0;
		{bresp, bvalid, bready, araddr, arlen, arvalid, arready} = '0;
		{rdata, rresp, rlast, rvalid, rready} = '0;
		awsize = 3'd3;
		arsize = 3'd3;
		awburst = 2'd1;
		arburst = 2'd1;
		wstrb = '1;
		exp_sticky = '0;
		exp_count = 0;
		fault = -1;
		repeat (8) @(posedge aclk);
		@(negedge aclk);
		rst = 0;
		check("violation_valid", 64'(violation_valid), 64'd0);
		check("violation_word", 64'(violation_word), 64'd0);
		check("violation_sticky", 64'(violation_sticky), 64'd0);
		check("violation_count", 64'(violation_count), 64'd0);
		for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
			@(negedge aclk);
			check("violation_valid", 64'(violation_valid), 64'(pred_q != 0));
			check("violation_word", 64'(violation_word), 64'(pred_q));
			if (cyc < LEGAL_CYCLES) begin
				check("violation_valid", 64'(violation_valid), 64'd0);
				check("violation_word", 64'(violation_word), 64'd0);
			end
			drive_cycle(cyc);
		end
		@(negedge aclk);
		check("violation_sticky", 64'(violation_sticky), 64'(exp_sticky));
		check("violation_count", 64'(violation_count), 64'(exp_count));
		$display("checks=%0d errors=%0d predicted_reports=%0d", checks, errors, exp_count);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Ends a run that stops making progress
	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the traffic loop finished");
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* logic/axi_protocol_monitor.sv */
// Top of the passive AXI4 monitor, connect every bus signal as input and read the violation outputs
`default_nettype none

`include "axi_monitor_consts.svh"

module axi_protocol_monitor (
	input logic aclk,
	input logic rst,
	input logic [`AXI_MON_ADDR_WIDTH-1:0] awaddr,
	input logic [`AXI_MON_LEN_WIDTH-1:0] awlen,
	input logic [2:0] awsize,
	input logic [1:0] awburst,
	input logic awvalid,
	input logic awready,
	input logic [`AXI_MON_DATA_WIDTH-1:0] wdata,
	input logic [`AXI_MON_STRB_WIDTH-1:0] wstrb,
	input logic wlast,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	input logic [`AXI_MON_ADDR_WIDTH-1:0] araddr,
	input logic [`AXI_MON_LEN_WIDTH-1:0] arlen,
	input logic [2:0] arsize,
	input logic [1:0] arburst,
	input logic arvalid,
	input logic arready,
	input logic [`AXI_MON_DATA_WIDTH-1:0] rdata,
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,
	input logic rready,
	output logic violation_valid,
	output logic [`AXI_MON_VIOL_WIDTH-1:0] violation_word,
	output logic [`AXI_MON_VIOL_WIDTH-1:0] violation_sticky,
	output logic [15:0] violation_count
);

	// Flags of the current cycle from each direction
	axi_monitor_pkg::wr_flags_t wr_flags;
	axi_monitor_pkg::rd_flags_t rd_flags;

	// The two directions share nothing and are checked side by side
	axi_write_checker i_wr_check (
		.aclk(aclk), .rst(rst),
		.awaddr(awaddr), .awlen(awlen), .awsize(awsize), .awburst(awburst),
		.awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.wr_flags(wr_flags)
	);

	axi_read_checker i_rd_check (
		.aclk(aclk), .rst(rst),
		.araddr(araddr), .arlen(arlen), .arsize(arsize), .arburst(arburst),
		.arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rlast(rlast), .rvalid(rvalid), .rready(rready),
		.rd_flags(rd_flags)
	);

	violation_reporter i_report (
		.aclk(aclk), .rst(rst),
		.wr_flags(wr_flags), .rd_flags(rd_flags),
		.violation_valid(violation_valid), .violation_word(violation_word),
		.violation_sticky(violation_sticky), .violation_count(violation_count)
	);

endmodule

`default_nettype wire

/* logic/violation_reporter.sv */
// Registers the combined write and read flags as a violation strobe with sticky and count state
`default_nettype none

`include "axi_monitor_consts.svh"

module violation_reporter (
	input logic aclk,
	input logic rst,
	input axi_monitor_pkg::wr_flags_t wr_flags,
	input axi_monitor_pkg::rd_flags_t rd_flags,
	output logic violation_valid,
	output logic [`AXI_MON_VIOL_WIDTH-1:0] violation_word,
	output logic [`AXI_MON_VIOL_WIDTH-1:0] violation_sticky,
	output logic [15:0] violation_count
);

	// Word under construction for the current bus cycle
	axi_monitor_pkg::violation_word_u word_now;
	logic any_now;

	// Fill the word field by field so the bit order follows the flag types
	always_comb begin
		word_now.named.wr = wr_flags;
		word_now.named.rd = rd_flags;
	end

	assign any_now = |word_now.raw;

	// Everything here is registered at the edge that samples the offence
	// Reset also hides any flag raised from stale checker history in that cycle
	always_ff @(posedge aclk) begin
		if (rst) begin
			violation_valid <= 1'b0;
			violation_word <= '0;
			violation_sticky <= '0;
			violation_count <= '0;
		end else begin
			violation_valid <= any_now;
			violation_word <= word_now.raw;
			violation_sticky <= violation_sticky | word_now.raw;
			// Counts cycles with a report, not individual flags, and stops at the top
			if (any_now && (violation_count != 16'hFFFF)) begin
				violation_count <= violation_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/axi_read_checker.sv */
// Checks the AR and R channels for stability, last placement and unrequested read data
`default_nettype none

`include "axi_monitor_consts.svh"

module axi_read_checker (
	input logic aclk,
	input logic rst,
	input logic [`AXI_MON_ADDR_WIDTH-1:0] araddr,
	input logic [`AXI_MON_LEN_WIDTH-1:0] arlen,
	input logic [2:0] arsize,
	input logic [1:0] arburst,
	input logic arvalid,
	input logic arready,
	input logic [`AXI_MON_DATA_WIDTH-1:0] rdata,
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,
	input logic rready,
	output axi_monitor_pkg::rd_flags_t rd_flags
);

	logic [`AXI_MON_ADDR_WIDTH+`AXI_MON_LEN_WIDTH+4:0] ar_payload;
	logic [`AXI_MON_DATA_WIDTH+2:0] r_payload;
	logic ar_unstable;
	logic ar_dropped;
	logic r_unstable;
	logic r_dropped;
	logic r_last_early;
	logic r_last_missing;
	logic r_without_request;

	// Same field set as the write address channel
	assign ar_payload = {araddr, arlen, arsize, arburst};
	// rlast is part of the beat and must hold with the data
	assign r_payload = {rdata, rresp, rlast};

	channel_stability_checker #(.WIDTH($bits(ar_payload))) i_ar_stable (
		.aclk(aclk), .rst(rst), .valid(arvalid), .ready(arready),
		.payload(ar_payload), .unstable(ar_unstable), .dropped(ar_dropped)
	);

	channel_stability_checker #(.WIDTH($bits(r_payload))) i_r_stable (
		.aclk(aclk), .rst(rst), .valid(rvalid), .ready(rready),
		.payload(r_payload), .unstable(r_unstable), .dropped(r_dropped)
	);

	// Read data always answers an accepted AR, so a beat with nothing queued is a fault
	// Read bursts end with the last beat, no response channel needs the completion
	burst_length_tracker i_r_bursts (
		.aclk(aclk), .rst(rst),
		.addr_accept(arvalid && arready), .burst_len(arlen),
		.beat_accept(rvalid && rready), .beat_last(rlast),
		.last_early(r_last_early), .last_missing(r_last_missing),
		.without_request(r_without_request), .burst_done()
	);

	always_comb begin
		rd_flags.ar_unstable = ar_unstable;
		rd_flags.ar_valid_dropped = ar_dropped;
		rd_flags.r_unstable = r_unstable;
		rd_flags.r_valid_dropped = r_dropped;
		rd_flags.r_last_early = r_last_early;
		rd_flags.r_last_missing = r_last_missing;
		rd_flags.r_without_request = r_without_request;
	end

endmodule

`default_nettype wire

/* logic/axi_write_checker.sv */
// Checks the AW, W and B channels for stability, last placement and response ordering
`default_nettype none

`include "axi_monitor_consts.svh"

module axi_write_checker (
	input logic aclk,
	input logic rst,
	input logic [`AXI_MON_ADDR_WIDTH-1:0] awaddr,
	input logic [`AXI_MON_LEN_WIDTH-1:0] awlen,
	input logic [2:0] awsize,
	input logic [1:0] awburst,
	input logic awvalid,
	input logic awready,
	input logic [`AXI_MON_DATA_WIDTH-1:0] wdata,
	input logic [`AXI_MON_STRB_WIDTH-1:0] wstrb,
	input logic wlast,
	input logic wvalid,
	input logic wready,
	input logic [1:0] bresp,
	input logic bvalid,
	input logic bready,
	output axi_monitor_pkg::wr_flags_t wr_flags
);

	logic [`AXI_MON_ADDR_WIDTH+`AXI_MON_LEN_WIDTH+4:0] aw_payload;
	logic [`AXI_MON_DATA_WIDTH+`AXI_MON_STRB_WIDTH:0] w_payload;
	logic aw_unstable;
	logic aw_dropped;
	logic w_unstable;
	logic w_dropped;
	logic b_unstable;
	logic b_dropped;
	logic w_last_early;
	logic w_last_missing;
	logic w_without_request;
	logic burst_done;
	logic b_hs;
	logic b_take;
	logic done_give;
	// Write bursts whose last beat went through and which still wait for their response
	logic [$clog2(`AXI_MON_MAX_OUTSTANDING):0] done_cnt;

	// Every control field of the address must hold during a stall, not just the address
	assign aw_payload = {awaddr, awlen, awsize, awburst};
	assign w_payload = {wdata, wstrb, wlast};

	channel_stability_checker #(.WIDTH($bits(aw_payload))) i_aw_stable (
		.aclk(aclk), .rst(rst), .valid(awvalid), .ready(awready),
		.payload(aw_payload), .unstable(aw_unstable), .dropped(aw_dropped)
	);

	channel_stability_checker #(.WIDTH($bits(w_payload))) i_w_stable (
		.aclk(aclk), .rst(rst), .valid(wvalid), .ready(wready),
		.payload(w_payload), .unstable(w_unstable), .dropped(w_dropped)
	);

	channel_stability_checker #(.WIDTH(2)) i_b_stable (
		.aclk(aclk), .rst(rst), .valid(bvalid), .ready(bready),
		.payload(bresp), .unstable(b_unstable), .dropped(b_dropped)
	);

	// Address is expected ahead of its data, so AW handshakes fill the length queue
	burst_length_tracker i_w_bursts (
		.aclk(aclk), .rst(rst),
		.addr_accept(awvalid && awready), .burst_len(awlen),
		.beat_accept(wvalid && wready), .beat_last(wlast),
		.last_early(w_last_early), .last_missing(w_last_missing),
		.without_request(w_without_request), .burst_done(burst_done)
	);

	assign b_hs = bvalid && bready;
	// A response consumes one completed burst if there is one
	assign b_take = b_hs && (done_cnt != 0);
	// Completions past the tracked depth are dropped unless a response frees a slot
	assign done_give = burst_done && ((done_cnt != `AXI_MON_MAX_OUTSTANDING) || b_take);

	always_ff @(posedge aclk) begin
		if (rst) begin
			done_cnt <= '0;
		end else begin
			case ({done_give, b_take})
				2'b10: done_cnt <= done_cnt + 1'b1;
				2'b01: done_cnt <= done_cnt - 1'b1;
				default: done_cnt <= done_cnt;
			endcase
		end
	end

	always_comb begin
		wr_flags.aw_unstable = aw_unstable;
		wr_flags.aw_valid_dropped = aw_dropped;
		wr_flags.w_unstable = w_unstable;
		wr_flags.w_valid_dropped = w_dropped;
		wr_flags.w_last_early = w_last_early;
		wr_flags.w_last_missing = w_last_missing;
		wr_flags.w_without_request = w_without_request;
		wr_flags.b_unstable = b_unstable;
		wr_flags.b_valid_dropped = b_dropped;
		// Response with no finished burst behind it, judged on the count before this edge
		wr_flags.b_without_request = b_hs && (done_cnt == 0);
	end

endmodule

`default_nettype wire

/* logic/burst_length_tracker.sv */
// Queues accepted burst lengths and checks where the last flag falls on the data beats of a channel
`default_nettype none

`include "axi_monitor_consts.svh"

module burst_length_tracker (
	input logic aclk,
	input logic rst,
	input logic addr_accept,
	input logic [`AXI_MON_LEN_WIDTH-1:0] burst_len,
	input logic beat_accept,
	input logic beat_last,
	output logic last_early,
	output logic last_missing,
	output logic without_request,
	output logic burst_done
);

	// Lengths of accepted but unfinished bursts, oldest at rd_ptr
	logic [`AXI_MON_LEN_WIDTH-1:0] len_q [`AXI_MON_MAX_OUTSTANDING];
	logic [$clog2(`AXI_MON_MAX_OUTSTANDING)-1:0] wr_ptr;
	logic [$clog2(`AXI_MON_MAX_OUTSTANDING)-1:0] rd_ptr;
	// Number of queued bursts, one bit wider than the pointers to reach the full depth
	logic [$clog2(`AXI_MON_MAX_OUTSTANDING):0] used;
	// Beats already accepted for the head burst
	logic [`AXI_MON_LEN_WIDTH-1:0] beat_cnt;
	logic empty;
	logic full;
	logic final_beat;
	logic push;
	logic pop;

	assign empty = (used == 0);
	assign full = (used == `AXI_MON_MAX_OUTSTANDING);

	// AXLEN counts beats minus one, so the last beat index equals the length field
	assign final_beat = (beat_cnt == len_q[rd_ptr]);

	// The head burst retires on its final beat or on an early last, whichever comes first
	assign pop = beat_accept && !empty && (final_beat || beat_last);

	// A full queue still takes a new burst if one retires in the same cycle
	assign push = addr_accept && (!full || pop);

	assign last_missing = beat_accept && !empty && final_beat && !beat_last;
	assign last_early = beat_accept && !empty && !final_beat && beat_last;
	assign without_request = beat_accept && empty;
	assign burst_done = pop;

	always_ff @(posedge aclk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used <= '0;
			beat_cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			// Counting restarts for the next burst in the queue
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				beat_cnt <= '0;
			end else if (beat_accept && !empty) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
			case ({push, pop})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	// Length storage needs no reset, entries are only read once counted in used
	always_ff @(posedge aclk) begin
		if (push) begin
			len_q[wr_ptr] <= burst_len;
		end
	end

endmodule

`default_nettype wire

/* logic/channel_stability_checker.sv */
// Watches one valid/ready channel and flags payload changes or a dropped valid during a stall
`default_nettype none

module channel_stability_checker #(
	parameter int WIDTH = 8
) (
	input logic aclk,
	input logic rst,
	input logic valid,
	input logic ready,
	input logic [WIDTH-1:0] payload,
	output logic unstable,
	output logic dropped
);

	// Set when the previous edge sampled valid high with ready low
	logic stall_q;
	// Payload as it was at that stalled edge
	logic [WIDTH-1:0] payload_q;

	// A handshake or a falling valid ends the stall, so the flag simply follows the stall term
	always_ff @(posedge aclk) begin
		if (rst) begin
			stall_q <= 1'b0;
		end else begin
			stall_q <= valid && !ready;
		end
	end

	// The copy only matters while stall_q is set
	always_ff @(posedge aclk) begin
		if (valid && !ready) begin
			payload_q <= payload;
		end
	end

	// Still valid after a stall, the payload must match what was offered
	assign unstable = stall_q && valid && (payload != payload_q);

	// Valid must hold until the transfer completes
	assign dropped = stall_q && !valid;

endmodule

`default_nettype wire

/* logic/axi_monitor_pkg.sv */
// Flag and violation word types shared by the AXI4 monitor checkers, reporter and testbench
`default_nettype none

`include "axi_monitor_consts.svh"

package axi_monitor_pkg;

	// One bit per write side rule, the first field lands in the MSB
	typedef struct packed {
		logic aw_unstable;
		logic aw_valid_dropped;
		logic w_unstable;
		logic w_valid_dropped;
		logic w_last_early;
		logic w_last_missing;
		logic w_without_request;
		logic b_unstable;
		logic b_valid_dropped;
		logic b_without_request;
	} wr_flags_t;

	// One bit per read side rule, same ordering convention
	typedef struct packed {
		logic ar_unstable;
		logic ar_valid_dropped;
		logic r_unstable;
		logic r_valid_dropped;
		logic r_last_early;
		logic r_last_missing;
		logic r_without_request;
	} rd_flags_t;

	// The reported word, seen either as the two flag groups or as a flat vector
	// Write flags occupy the upper ten bits and read flags the lower seven
	typedef union packed {
		struct packed {
			wr_flags_t wr;
			rd_flags_t rd;
		} named;
		logic [`AXI_MON_VIOL_WIDTH-1:0] raw;
	} violation_word_u;

endpackage

`default_nettype wire

/* logic/axi_monitor_consts.svh */
// Sizing macros for the AXI4 monitor, included by the package and by every RTL file that needs them
`ifndef AXI_MONITOR_CONSTS_SVH
`define AXI_MONITOR_CONSTS_SVH

// Width of AWADDR and ARADDR
`define AXI_MON_ADDR_WIDTH 32

// Width of WDATA and RDATA, the monitored bus is 64 bits wide
`define AXI_MON_DATA_WIDTH 64

// One strobe lane per data byte
`define AXI_MON_STRB_WIDTH 8

// Width of AWLEN and ARLEN, a burst carries up to 256 beats
`define AXI_MON_LEN_WIDTH 8

// Bursts tracked per direction, beyond this they are ignored
// Must stay a power of two because the queue pointers wrap naturally
`define AXI_MON_MAX_OUTSTANDING 4

// Ten write flags followed by seven read flags
`define AXI_MON_VIOL_WIDTH 17

`endif
